/* hdl/wb_pkg.sv */
package wb_pkg;

  // ------------------------------------------------------------------------
  // Wishbone side widths
  // ------------------------------------------------------------------------

  // Byte address as seen by the SDRAM controller
  localparam int WB_ADDR_W = 25;
  // Bus data width
  localparam int WB_DATA_W = 32;
  // One select bit per byte lane
  localparam int WB_SEL_W  = WB_DATA_W / 8;

  // Write-data FIFO entry
  typedef struct packed {
    // Active-low byte enables for the SDRAM side
    logic [WB_SEL_W-1:0]  mask_n;
    // Payload
    logic [WB_DATA_W-1:0] data;
  } wb_wdata_t;

endpackage

/* hdl/sdrc_pkg.sv */
package sdrc_pkg;

  // ------------------------------------------------------------------------
  // SDRAM controller request port
  // ------------------------------------------------------------------------

  // Request length field width
  localparam int SDR_LEN_W = 9;
  // Single transfer per request
  localparam logic [SDR_LEN_W-1:0] SDR_REQ_LEN_SINGLE = 9'd1;

  // Command FIFO entry
  typedef struct packed {
    // 1 for read, 0 for write
    logic                          wr_n;
    // Request address
    logic [wb_pkg::WB_ADDR_W-1:0] addr;
  } sdr_cmd_t;

  // FIFO depths
  localparam int CMD_FIFO_DEPTH   = 4;
  // Deeper so writes can queue behind a stalled request
  localparam int WDATA_FIFO_DEPTH = 8;
  // At most one read in flight
  localparam int RDATA_FIFO_DEPTH = 4;

endpackage

/* hdl/fifo_if.sv */
interface fifo_if #(
  parameter int WIDTH = 8
);

  // Write side
  logic             push;
  logic [WIDTH-1:0] push_data;
  logic             full;

  // Read side
  logic             pop;
  logic [WIDTH-1:0] pop_data;
  logic             empty;

  // Block that fills the FIFO
  modport producer (
    output push, push_data,
    input  full
  );

  // Block that drains the FIFO
  modport consumer (
    output pop,
    input  pop_data, empty
  );

  // The FIFO itself
  modport storage (
    input  push, push_data, pop,
    output full, empty, pop_data
  );

endinterface

/* hdl/sync_fifo.sv */
module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic      sdram_clk,
  input  logic      wb_clk_i,
  fifo_if.storage   fifo_port
);

  // Pointer and occupancy widths
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage array
  logic [WIDTH-1:0] mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_nxt;
  logic             full_q;
  logic             empty_q;

  // Accepted transfers only
  logic             push_ok;
  logic             pop_ok;

  // ------------------------------------------------------------------------
  // Handshake qualification
  // ------------------------------------------------------------------------

  assign push_ok = fifo_port.push & ~full_q;
  assign pop_ok  = fifo_port.pop & ~empty_q;

  // Occupancy after this edge
  always_comb begin
    count_nxt = count_q;
    if (push_ok && !pop_ok) begin
      count_nxt = count_q + 1'b1;
    end else if (pop_ok && !push_ok) begin
      count_nxt = count_q - 1'b1;
    end
  end

  // ------------------------------------------------------------------------
  // Pointers, count and flags
  // ------------------------------------------------------------------------

  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      full_q   <= 1'b0;
      empty_q  <= 1'b1;
    end else begin
      // Wrap at DEPTH so non power of two depths work
      if (push_ok) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_nxt;
      // Flags follow the new count
      full_q  <= (count_nxt == CNT_W'(DEPTH));
      empty_q <= (count_nxt == '0);
    end
  end

  // Write port
  always_ff @(posedge sdram_clk) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= fifo_port.push_data;
    end
  end

  // Head falls through
  assign fifo_port.pop_data = mem_q[rd_ptr_q];
  assign fifo_port.full     = full_q;
  assign fifo_port.empty    = empty_q;

endmodule

/* hdl/wb_req_ctrl.sv */
module wb_req_ctrl (
  input  logic                          sdram_clk,
  input  logic                          wb_clk_i,
  // Wishbone slave
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [wb_pkg::WB_ADDR_W-1:0] wb_addr_i,
  input  logic [wb_pkg::WB_DATA_W-1:0] wb_dat_i,
  input  logic [wb_pkg::WB_SEL_W-1:0]  wb_sel_i,
  output logic                          wb_ack_o,
  output logic [wb_pkg::WB_DATA_W-1:0] wb_dat_o,
  // FIFO sides
  fifo_if.producer                      cmd_if,
  fifo_if.producer                      wdata_if,
  fifo_if.consumer                      rdata_if
);

  import wb_pkg::*;
  import sdrc_pkg::*;

  logic       wb_act;
  logic       wr_cyc;
  logic       rd_cyc;
  logic       wr_ack;
  logic       rd_ack;
  logic       rd_cmd_push;
  // One read outstanding at the controller
  logic       rd_pend_q;
  sdr_cmd_t   cmd_word;
  wb_wdata_t  wdata_word;

  // ------------------------------------------------------------------------
  // Cycle decode and acknowledge
  // ------------------------------------------------------------------------

  assign wb_act = wb_cyc_i & wb_stb_i;
  assign wr_cyc = wb_act & wb_we_i;
  assign rd_cyc = wb_act & ~wb_we_i;

  // Write needs room for both command and data
  assign wr_ack = wr_cyc & ~cmd_if.full & ~wdata_if.full;
  // Read acks together with its data
  assign rd_ack = rd_cyc & ~rdata_if.empty;

  assign wb_ack_o = wr_ack | rd_ack;
  assign wb_dat_o = rdata_if.pop_data;

  // ------------------------------------------------------------------------
  // FIFO pushes
  // ------------------------------------------------------------------------

  // Read command goes out once per waiting cycle
  assign rd_cmd_push = rd_cyc & ~cmd_if.full & ~rd_pend_q;

  always_comb begin
    cmd_word.wr_n     = ~wb_we_i;
    cmd_word.addr     = wb_addr_i;
    // SDRAM side wants active-low enables
    wdata_word.mask_n = ~wb_sel_i;
    wdata_word.data   = wb_dat_i;
  end

  assign cmd_if.push        = wr_ack | rd_cmd_push;
  assign cmd_if.push_data   = cmd_word;
  assign wdata_if.push      = wr_ack;
  assign wdata_if.push_data = wdata_word;
  // Consume read word on ack
  assign rdata_if.pop       = rd_ack;

  // Pending read flag
  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      rd_pend_q <= 1'b0;
    end else if (rd_cmd_push) begin
      rd_pend_q <= 1'b1;
    end else if (rd_ack) begin
      rd_pend_q <= 1'b0;
    end
  end

endmodule

/* hdl/wb2sdrc.sv */
module wb2sdrc (
  // Clock and reset
  input  logic                           sdram_clk,
  input  logic                           wb_clk_i,
  // Wishbone slave
  input  logic                           wb_cyc_i,
  input  logic                           wb_stb_i,
  input  logic                           wb_we_i,
  input  logic [wb_pkg::WB_ADDR_W-1:0]  wb_addr_i,
  input  logic [wb_pkg::WB_DATA_W-1:0]  wb_dat_i,
  input  logic [wb_pkg::WB_SEL_W-1:0]   wb_sel_i,
  output logic                           wb_ack_o,
  output logic [wb_pkg::WB_DATA_W-1:0]  wb_dat_o,
  // SDRAM controller request
  output logic                           sdr_req_o,
  output logic                           sdr_req_wr_n_o,
  output logic [wb_pkg::WB_ADDR_W-1:0]  sdr_req_addr_o,
  output logic [sdrc_pkg::SDR_LEN_W-1:0] sdr_req_len_o,
  input  logic                           sdr_req_ack_i,
  // Write data return
  output logic [wb_pkg::WB_SEL_W-1:0]   sdr_wr_en_n_o,
  input  logic                           sdr_wr_next_i,
  output logic [wb_pkg::WB_DATA_W-1:0]  sdr_wr_data_o,
  // Read data return
  input  logic                           sdr_rd_valid_i,
  input  logic [wb_pkg::WB_DATA_W-1:0]  sdr_rd_data_i
);

  import wb_pkg::*;
  import sdrc_pkg::*;

  // Head entries unpacked for the ports
  sdr_cmd_t  cmd_head;
  wb_wdata_t wdata_head;

  // ------------------------------------------------------------------------
  // FIFO connections
  // ------------------------------------------------------------------------

  fifo_if #(.WIDTH($bits(sdr_cmd_t)))  cmd_if ();
  fifo_if #(.WIDTH($bits(wb_wdata_t))) wdata_if ();
  fifo_if #(.WIDTH(WB_DATA_W))         rdata_if ();

  // Wishbone decode and pushes
  wb_req_ctrl u_req_ctrl (
    .sdram_clk (sdram_clk),
    .wb_clk_i  (wb_clk_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_addr_i (wb_addr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_sel_i  (wb_sel_i),
    .wb_ack_o  (wb_ack_o),
    .wb_dat_o  (wb_dat_o),
    .cmd_if    (cmd_if.producer),
    .wdata_if  (wdata_if.producer),
    .rdata_if  (rdata_if.consumer)
  );

  // Address and direction
  sync_fifo #(.WIDTH($bits(sdr_cmd_t)), .DEPTH(CMD_FIFO_DEPTH)) u_cmd_fifo (
    .sdram_clk (sdram_clk),
    .wb_clk_i  (wb_clk_i),
    .fifo_port (cmd_if.storage)
  );

  // Write payload with byte mask
  sync_fifo #(.WIDTH($bits(wb_wdata_t)), .DEPTH(WDATA_FIFO_DEPTH)) u_wdata_fifo (
    .sdram_clk (sdram_clk),
    .wb_clk_i  (wb_clk_i),
    .fifo_port (wdata_if.storage)
  );

  // Read return data
  sync_fifo #(.WIDTH(WB_DATA_W), .DEPTH(RDATA_FIFO_DEPTH)) u_rdata_fifo (
    .sdram_clk (sdram_clk),
    .wb_clk_i  (wb_clk_i),
    .fifo_port (rdata_if.storage)
  );

  // ------------------------------------------------------------------------
  // Controller side mapping
  // ------------------------------------------------------------------------

  // Request held until the controller takes it
  assign cmd_if.pop      = sdr_req_ack_i;
  assign cmd_head        = cmd_if.pop_data;
  assign sdr_req_o       = ~cmd_if.empty;
  assign sdr_req_wr_n_o  = cmd_head.wr_n;
  assign sdr_req_addr_o  = cmd_head.addr;
  // Always single transfers
  assign sdr_req_len_o   = SDR_REQ_LEN_SINGLE;

  // Next write word on demand
  assign wdata_if.pop    = sdr_wr_next_i;
  assign wdata_head      = wdata_if.pop_data;
  assign sdr_wr_en_n_o   = wdata_head.mask_n;
  assign sdr_wr_data_o   = wdata_head.data;

  // Read data straight in
  assign rdata_if.push      = sdr_rd_valid_i;
  assign rdata_if.push_data = sdr_rd_data_i;

endmodule

/* tests/wb2sdrc_properties.sv */
module wb2sdrc_properties (
  input logic                          sdram_clk,
  input logic                          wb_clk_i,
  input logic                          wb_cyc_i,
  input logic                          wb_stb_i,
  input logic                          wb_we_i,
  input logic                          wb_ack_o,
  input logic                          rd_pend_i,
  input logic                          sdr_req_o,
  input logic                          sdr_req_ack_i,
  input logic                          sdr_req_wr_n_o,
  input logic [wb_pkg::WB_ADDR_W-1:0] sdr_req_addr_o,
  // One bit per FIFO in the order cmd, wdata, rdata
  input logic [2:0]                    push_i,
  input logic [2:0]                    full_i,
  input logic [2:0]                    pop_i,
  input logic [2:0]                    empty_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // ------------------------------------------------------------------------
  // FIFO occupancy rules
  // ------------------------------------------------------------------------

  a_push_full : assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
    (push_i & full_i) == 3'b000)
    else $error("push into a full FIFO");

  a_pop_empty : assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
    (pop_i & empty_i) == 3'b000)
    else $error("pop from an empty FIFO");

  // ------------------------------------------------------------------------
  // Bus handshakes
  // ------------------------------------------------------------------------

  // Ack only inside an active cycle, and a read ack only for a pending read
  a_ack_active : assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
    wb_ack_o |-> (wb_cyc_i && wb_stb_i && (wb_we_i || rd_pend_i)))
    else $error("wb_ack_o outside an active Wishbone cycle or without a pending read");

  // Pending request held until taken
  a_req_stable : assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
    (sdr_req_o && !sdr_req_ack_i) |=> ($stable(sdr_req_addr_o) && $stable(sdr_req_wr_n_o)))
    else $error("request changed while waiting for acknowledge");

endmodule

bind wb2sdrc wb2sdrc_properties u_props (
  .sdram_clk      (sdram_clk),
  .wb_clk_i       (wb_clk_i),
  .wb_cyc_i       (wb_cyc_i),
  .wb_stb_i       (wb_stb_i),
  .wb_we_i        (wb_we_i),
  .wb_ack_o       (wb_ack_o),
  .rd_pend_i      (u_req_ctrl.rd_pend_q),
  .sdr_req_o      (sdr_req_o),
  .sdr_req_ack_i  (sdr_req_ack_i),
  .sdr_req_wr_n_o (sdr_req_wr_n_o),
  .sdr_req_addr_o (sdr_req_addr_o),
  .push_i         ({cmd_if.push, wdata_if.push, rdata_if.push}),
  .full_i         ({cmd_if.full, wdata_if.full, rdata_if.full}),
  .pop_i          ({cmd_if.pop, wdata_if.pop, rdata_if.pop}),
  .empty_i        ({cmd_if.empty, wdata_if.empty, rdata_if.empty})
);

/* tests/tb_wb2sdrc.sv */
module tb_wb2sdrc;
  timeunit 1ns;
  timeprecision 100ps;

  import wb_pkg::*;
  import sdrc_pkg::*;

  localparam int NROWS = 14;
  // Hold-off of the back-pressure row
  localparam int STALL = 50;
  // Every request is one transfer
  localparam logic [SDR_LEN_W-1:0] EXP_LEN = 1;

  // Zero hold-off picks a random delay
  typedef struct packed {
    logic                 we;
    logic [WB_ADDR_W-1:0] addr;
    logic [WB_DATA_W-1:0] data;
    logic [WB_SEL_W-1:0]  sel;
    int                   hold;
  } row_t;

  // Columns are we, addr, data, sel, hold
  row_t rows [NROWS] = '{
    '{1'b1, 25'h010, 32'h1122_3344, 4'hf, 2},
    '{1'b1, 25'h014, 32'haabb_ccdd, 4'hf, 0},
    '{1'b0, 25'h010, 32'h0000_0000, 4'hf, 3},
    '{1'b1, 25'h010, 32'h5566_7788, 4'h5, 0},
    '{1'b0, 25'h010, 32'h0000_0000, 4'hf, 30},
    '{1'b0, 25'h100, 32'h0000_0000, 4'hf, 0},
    '{1'b1, 25'h020, 32'h0bad_f00d, 4'hf, STALL},
    '{1'b1, 25'h024, 32'h0102_0304, 4'hf, 0},
    '{1'b1, 25'h028, 32'ha0b0_c0d0, 4'h3, 0},
    '{1'b1, 25'h02c, 32'h1357_9bdf, 4'hf, 1},
    '{1'b1, 25'h030, 32'h2468_ace0, 4'h8, 0},
    '{1'b1, 25'h034, 32'hdead_beef, 4'h6, 0},
    '{1'b0, 25'h028, 32'h0000_0000, 4'hf, 0},
    '{1'b0, 25'h014, 32'h0000_0000, 4'hf, 1}
  };

  logic                 sdram_clk = 1'b0;
  logic                 wb_clk_i, wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
  logic [WB_ADDR_W-1:0] wb_addr_i, sdr_req_addr_o;
  logic [WB_DATA_W-1:0] wb_dat_i, wb_dat_o, sdr_wr_data_o, sdr_rd_data_i;
  logic [WB_SEL_W-1:0]  wb_sel_i, sdr_wr_en_n_o;
  logic                 sdr_req_o, sdr_req_wr_n_o, sdr_req_ack_i;
  logic [SDR_LEN_W-1:0] sdr_req_len_o;
  logic                 sdr_wr_next_i, sdr_rd_valid_i;

  // Expected contents from table writes, and the controller's own copy
  logic [WB_DATA_W-1:0] ref_mem [logic [WB_ADDR_W-1:0]];
  logic [WB_DATA_W-1:0] sdr_mem [logic [WB_ADDR_W-1:0]];
  int seed = 91380;
  int cmd_cnt = 0;
  int wr_ack_cnt = 0;
  int rd_ret_cnt = 0;
  int rd_ack_cnt = 0;
  logic verdict_shown = 1'b0;

  wb2sdrc u_wb2sdrc (.*);

  always #5 sdram_clk = ~sdram_clk;

  task automatic abort_run(input string msg);
    verdict_shown = 1'b1;
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  // Unwritten locations read back a pattern of the full address
  function automatic logic [WB_DATA_W-1:0] fill_word(input logic [WB_ADDR_W-1:0] a);
    return {7'h5a, a} ^ {a[15:0], a[24:9]};
  endfunction

  // Lanes with sel set take the new byte
  function automatic logic [WB_DATA_W-1:0] merge_bytes(input logic [WB_DATA_W-1:0] old_w,
                                                       input logic [WB_DATA_W-1:0] new_w,
                                                       input logic [WB_SEL_W-1:0]  sel);
    logic [WB_DATA_W-1:0] w;
    w = old_w;
    for (int b = 0; b < WB_SEL_W; b++) begin
      if (sel[b]) begin
        w[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return w;
  endfunction

  // Write acks as taken at each edge
  always @(posedge sdram_clk) begin
    if (wb_ack_o && wb_we_i) begin
      wr_ack_cnt <= wr_ack_cnt + 1;
    end
  end

  // --------------------------------------------------------------------------
  // SDRAM controller model
  // --------------------------------------------------------------------------

  initial begin : sdram_model
    row_t                 r;
    int                   hold;
    int                   stall_base;
    logic [WB_DATA_W-1:0] old_w;
    forever begin
      @(negedge sdram_clk);
      if (sdr_req_o) begin
        assert (cmd_cnt < NROWS) else abort_run("Extra command on sdr_req_o after the table");
        r = rows[cmd_cnt];
        assert (sdr_req_addr_o == r.addr) else abort_run($sformatf(
          "Error: sdr_req_addr_o = %h, expected %h", sdr_req_addr_o, r.addr));
        assert (sdr_req_wr_n_o == ~r.we) else abort_run($sformatf(
          "Error: sdr_req_wr_n_o = %h, expected %h", sdr_req_wr_n_o, ~r.we));
        assert (sdr_req_len_o == EXP_LEN) else abort_run($sformatf(
          "Error: sdr_req_len_o = %h, expected %h", sdr_req_len_o, EXP_LEN));
        hold = (r.hold != 0) ? r.hold : int'($unsigned($random(seed)) % 4);
        // Stalled write counts as the first one queued
        stall_base = wr_ack_cnt - 1;
        repeat (hold) begin
          @(negedge sdram_clk);
          assert (sdr_req_o) else abort_run("sdr_req_o dropped before the acknowledge");
        end
        if (r.hold == STALL) begin
          assert (wr_ack_cnt - stall_base == CMD_FIFO_DEPTH) else abort_run($sformatf(
            "Error: wb_ack_o writes in stall = %h, expected %h",
            wr_ack_cnt - stall_base, CMD_FIFO_DEPTH));
        end
        @(posedge sdram_clk);
        sdr_req_ack_i <= 1'b1;
        @(posedge sdram_clk);
        sdr_req_ack_i <= 1'b0;
        if (r.we) begin
          sdr_wr_next_i <= 1'b1;
          @(negedge sdram_clk);
          assert (sdr_wr_data_o == r.data) else abort_run($sformatf(
            "Error: sdr_wr_data_o = %h, expected %h", sdr_wr_data_o, r.data));
          assert (sdr_wr_en_n_o == ~r.sel) else abort_run($sformatf(
            "Error: sdr_wr_en_n_o = %h, expected %h", sdr_wr_en_n_o, ~r.sel));
          old_w = sdr_mem.exists(r.addr) ? sdr_mem[r.addr] : fill_word(r.addr);
          sdr_mem[r.addr] = merge_bytes(old_w, sdr_wr_data_o, ~sdr_wr_en_n_o);
          @(posedge sdram_clk);
          sdr_wr_next_i <= 1'b0;
        end else begin
          // Random read latency
          repeat (int'($unsigned($random(seed)) % 4)) @(posedge sdram_clk);
          sdr_rd_valid_i <= 1'b1;
          sdr_rd_data_i  <= sdr_mem.exists(r.addr) ? sdr_mem[r.addr] : fill_word(r.addr);
          rd_ret_cnt++;
          @(posedge sdram_clk);
          sdr_rd_valid_i <= 1'b0;
        end
        cmd_cnt++;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Wishbone master and table loop
  // --------------------------------------------------------------------------

  initial begin : wb_master
    logic [WB_DATA_W-1:0] exp_w;
    wb_clk_i       <= 1'b1;
    wb_cyc_i       <= 1'b0;
    wb_stb_i       <= 1'b0;
    wb_we_i        <= 1'b0;
    wb_addr_i      <= '0;
    wb_dat_i       <= '0;
    wb_sel_i       <= '0;
    sdr_req_ack_i  <= 1'b0;
    sdr_wr_next_i  <= 1'b0;
    sdr_rd_valid_i <= 1'b0;
    sdr_rd_data_i  <= '0;
    repeat (10) @(posedge sdram_clk);
    wb_clk_i <= 1'b0;
    @(negedge sdram_clk);
    assert (!wb_ack_o && !sdr_req_o) else abort_run("wb_ack_o or sdr_req_o high after reset");
    for (int i = 0; i < NROWS; i++) begin
      @(posedge sdram_clk);
      wb_cyc_i  <= 1'b1;
      wb_stb_i  <= 1'b1;
      wb_we_i   <= rows[i].we;
      wb_addr_i <= rows[i].addr;
      wb_dat_i  <= rows[i].data;
      wb_sel_i  <= rows[i].sel;
      // Hold the cycle until acknowledged
      @(negedge sdram_clk);
      while (!wb_ack_o) @(negedge sdram_clk);
      exp_w = ref_mem.exists(rows[i].addr) ? ref_mem[rows[i].addr] : fill_word(rows[i].addr);
      if (rows[i].we) begin
        ref_mem[rows[i].addr] = merge_bytes(exp_w, rows[i].data, rows[i].sel);
      end else begin
        assert (rd_ret_cnt > rd_ack_cnt) else abort_run("Read acknowledged before data returned");
        assert (wb_dat_o == exp_w) else abort_run($sformatf(
          "Error: wb_dat_o = %h, expected %h", wb_dat_o, exp_w));
        rd_ack_cnt++;
      end
    end
    @(posedge sdram_clk);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wait (cmd_cnt == NROWS);
    // Give a stray command time to reach the model
    repeat (5) @(negedge sdram_clk);
    verdict_shown = 1'b1;
    $display(">>> PASS");
    $finish;
  end

  initial begin : watchdog
    repeat (NROWS * 200) @(posedge sdram_clk);
    abort_run("Timeout: the transaction table did not complete in time");
  end

  final begin
    if (!verdict_shown) begin
      $display(">>> FAIL");
    end
  end

endmodule

/* list.f */
hdl/wb_pkg.sv
hdl/sdrc_pkg.sv
hdl/fifo_if.sv
hdl/sync_fifo.sv
hdl/wb_req_ctrl.sv
hdl/wb2sdrc.sv
tests/wb2sdrc_properties.sv
tests/tb_wb2sdrc.sv

/* run.sh */
#!/bin/sh
# Build and run the wb2sdrc testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module tb_wb2sdrc
# The simulation status is ignored here and the output decides
out=$(./obj_dir/Vtb_wb2sdrc 2>&1 || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qxF '>>> PASS'
